/* hdl/byteFifo.sv */
// byte FIFO, first-word fall-through, storage held inside
`default_nettype none

module byteFifo #(
   parameter int FifoDepth = unconfuserPkg::FifoDepth
) (
   input  logic                              Clk,
   input  logic                              Reset,
   input  logic                              push,
   input  logic [unconfuserPkg::ByteWidth-1:0] din,
   output logic                              full,
   input  logic                              pull,
   output logic [unconfuserPkg::ByteWidth-1:0] dout,
   output logic                              empty
);
   import unconfuserPkg::*;

   localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

   logic [ByteWidth-1:0] mem [FifoDepth];
   logic [PtrWidth-1:0]  wrPtr;
   logic [PtrWidth-1:0]  rdPtr;
   logic [PtrWidth:0]    count;
   logic                 doPush;
   logic                 doPull;

   function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] p);
      return (p == PtrWidth'(FifoDepth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full   = (count == (PtrWidth + 1)'(FifoDepth));
   assign empty  = (count == '0);
   assign doPush = push && !full;
   assign doPull = pull && !empty;
   assign dout   = mem[rdPtr]; // head shows as soon as it is written

   always_ff @(posedge Clk or posedge Reset) begin
      if (Reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush)
            wrPtr <= nextPtr(wrPtr);
         if (doPull)
            rdPtr <= nextPtr(rdPtr);
         if (doPush && !doPull)
            count <= count + 1'b1;
         else if (doPull && !doPush)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge Clk) begin
      if (doPush)
         mem[wrPtr] <= din;
   end

   // input side has no back-pressure, a push here would be lost
   noOverflow: assert property (@(posedge Clk) disable iff (Reset) !(push && full))
      else $error("byteFifo push while full");
   noUnderflow: assert property (@(posedge Clk) disable iff (Reset) !(pull && empty))
      else $error("byteFifo pull while empty");

endmodule

`default_nettype wire

/* hdl/keystreamGen.sv */
// keystream generator
// four pads, pad select and injector, loaded by config bytes, stepped either way
`default_nettype none

module keystreamGen (
   input  logic                               Clk,
   input  logic                               Reset,
   input  logic                               Cpush,
   input  logic [unconfuserPkg::CaddrWidth-1:0] Caddr,
   input  logic [unconfuserPkg::ByteWidth-1:0]  Cdata,
   keystreamIf.gen                            ks
);
   import unconfuserPkg::*;

   // pads 0..3, injector, pad select, each in the low bits
   logic [MaxPadWidth-1:0] ksReg [NumKsRegs];
   prnTap_t                tap;

   assign tap          = prnTap(prnSelect(ksReg[PadSelIdx]));
   assign ks.prn       = ksReg[tap.pad][tap.index];
   assign ks.padAmount = padAmountOf(ksReg[InjectorIdx]);

   always_ff @(posedge Clk or posedge Reset) begin
      if (Reset) begin
         for (int r = 0; r < NumKsRegs; r++)
            ksReg[r] <= '0;
      end else begin
         for (int r = 0; r < NumKsRegs; r++) begin
            if (Cpush)
               ksReg[r] <= cfgWrite(ksReg[r], RegWidth[r], RegBase[r], Caddr, Cdata);
            else if (ks.step && (r != InjectorIdx || ks.dir == Forward)) // injector only forward
               ksReg[r] <= lfsrStep(ksReg[r], RegPoly[r], RegWidth[r], ks.dir);
         end
      end
   end

   // configuration only lands while the control unit is idle
   cfgNotDuringStep: assert property (@(posedge Clk) disable iff (Reset) !(Cpush && ks.step))
      else $error("configuration write while keystream is stepping");

endmodule

`default_nettype wire

/* hdl/keystreamIf.sv */
// keystream link
// step requests from the control unit, PRN bit and step count back
`default_nettype none

interface keystreamIf;
   import unconfuserPkg::*;

   logic                      step;
   stepDir_t                  dir;
   logic                      load;      // word complete, sample padAmount
   logic                      prn;
   logic [PadAmountWidth-1:0] padAmount;

   modport gen (
      input  step, dir,
      output prn, padAmount
   );

   modport ctrl (
      output step, dir, load,
      input  prn, padAmount
   );

endinterface

`default_nettype wire

/* hdl/unConfuser.sv */
// unconfuser top
// input FIFO, keystream generator, control unit, output FIFO
`default_nettype none

module unConfuser #(
   parameter int FifoDepth = unconfuserPkg::FifoDepth
) (
   input  logic                               Clk,
   input  logic                               Reset,
   input  logic                               PushIn,
   input  logic [unconfuserPkg::ByteWidth-1:0]  Din,
   input  logic [unconfuserPkg::CaddrWidth-1:0] Caddr,
   input  logic [unconfuserPkg::ByteWidth-1:0]  Cdata,
   input  logic                               Cpush,
   input  logic                               StopIn,
   output logic                               PushOut,
   output logic [unconfuserPkg::ByteWidth-1:0]  Dout
);
   import unconfuserPkg::*;

   logic [ByteWidth-1:0] inDout;
   logic                 inEmpty;
   logic                 inPull;
   logic [ByteWidth-1:0] outDin;
   logic                 outPush;
   logic                 outFull;
   logic                 outEmpty;

   keystreamIf ks ();

   byteFifo #(.FifoDepth(FifoDepth)) inputFifo (
      .Clk(Clk), .Reset(Reset),
      .push(PushIn), .din(Din), .full(),  // no back-pressure on the input
      .pull(inPull), .dout(inDout), .empty(inEmpty)
   );

   keystreamGen keystreamGen_inst (
      .Clk(Clk), .Reset(Reset),
      .Cpush(Cpush), .Caddr(Caddr), .Cdata(Cdata),
      .ks(ks.gen)
   );

   unconfuserCtrl unconfuserCtrl_inst (
      .Clk(Clk), .Reset(Reset),
      .inDout(inDout), .inEmpty(inEmpty), .inPull(inPull),
      .outFull(outFull), .outPush(outPush), .outDin(outDin),
      .ks(ks.ctrl)
   );

   byteFifo #(.FifoDepth(FifoDepth)) outputFifo (
      .Clk(Clk), .Reset(Reset),
      .push(outPush), .din(outDin), .full(outFull),
      .pull(PushOut && !StopIn), .dout(Dout), .empty(outEmpty)
   );

   assign PushOut = !outEmpty; // head byte valid

endmodule

`default_nettype wire

/* hdl/unconfuserCtrl.sv */
// unconfuser control
// gathers words, drives keystream steps, backward CRC, emits bytes
`default_nettype none

module unconfuserCtrl (
   input  logic                              Clk,
   input  logic                              Reset,
   input  logic [unconfuserPkg::ByteWidth-1:0] inDout,
   input  logic                              inEmpty,
   output logic                              inPull,
   input  logic                              outFull,
   output logic                              outPush,
   output logic [unconfuserPkg::ByteWidth-1:0] outDin,
   keystreamIf.ctrl                          ks
);
   import unconfuserPkg::*;

   ctrlState_t                state;
   logic [WordWidth-1:0]      word;
   logic [1:0]                byteCnt;    // bytes gathered or emitted
   logic [PadAmountWidth-1:0] stepAmount; // n for the current word
   logic [PadAmountWidth-1:0] stepCnt;
   logic                      lastStep;
   logic                      crcFb;

   assign inPull   = (state == Gather) && !inEmpty;
   assign ks.load  = inPull && (byteCnt == 2'd3);
   assign ks.step  = state inside {StepFw, StepBw, Restore};
   assign ks.dir   = (state == StepBw) ? Backward : Forward;
   assign outPush  = (state == Emit) && !outFull;
   assign outDin   = word[WordWidth-1 -: ByteWidth]; // most significant byte first
   assign lastStep = (stepCnt == PadAmountWidth'(1));
   assign crcFb    = word[0] ^ ks.prn;

   always_ff @(posedge Clk or posedge Reset) begin
      if (Reset) begin
         state      <= Idle;
         byteCnt    <= '0;
         stepAmount <= '0;
         stepCnt    <= '0;
      end else begin
         case (state)
            Idle: begin
               if (!inEmpty)
                  state <= Gather;
            end
            Gather: begin
               if (inPull)
                  byteCnt <= byteCnt + 1'b1;
               if (ks.load) begin
                  stepAmount <= ks.padAmount;
                  stepCnt    <= ks.padAmount;
                  state      <= StepFw;
               end
            end
            StepFw: begin
               stepCnt <= lastStep ? stepAmount : stepCnt - 1'b1;
               if (lastStep)
                  state <= StepBw;
            end
            StepBw: begin
               stepCnt <= lastStep ? stepAmount : stepCnt - 1'b1; // reloaded for Restore
               if (lastStep)
                  state <= Emit;
            end
            Emit: begin
               if (outPush) begin
                  byteCnt <= byteCnt + 1'b1;
                  if (byteCnt == 2'd3)
                     state <= Restore;
               end
            end
            Restore: begin
               stepCnt <= stepCnt - 1'b1;
               if (lastStep)
                  state <= inEmpty ? Idle : Gather;
            end
            default: state <= Idle;
         endcase
      end
   end

   // word register, shifted in, CRC'd backward, shifted out
   always_ff @(posedge Clk) begin
      if (inPull)
         word <= {word[WordWidth-ByteWidth-1:0], inDout};
      else if (state == StepBw)
         word <= {crcFb, word[WordWidth-1:1] ^
                  ({(WordWidth - 1){crcFb}} & PolyCrc[WordWidth-1:1])};
      else if (outPush)
         word <= word << ByteWidth;
   end

   // pads move only while a step count runs, never in Idle or Gather
   stepWithinCount: assert property (@(posedge Clk) disable iff (Reset)
      ks.step |-> (stepCnt != '0) && (stepCnt <= stepAmount))
      else $error("keystream step without a running step count");

endmodule

`default_nettype wire

/* hdl/unconfuserPkg.sv */
// unconfuser package
// widths, polynomials, configuration map, state types and keystream helpers
`default_nettype none

package unconfuserPkg;

   localparam int ByteWidth      = 8;
   localparam int WordWidth      = 32;
   localparam int CaddrWidth     = 7;
   localparam int PadAmountWidth = 6;
   localparam int FifoDepth      = 16;

   localparam int Pad0Width     = 160;
   localparam int Pad1Width     = 161;
   localparam int Pad2Width     = 162;
   localparam int Pad3Width     = 163;
   localparam int PadSelWidth   = 40;
   localparam int InjectorWidth = 32;
   localparam int MaxPadWidth   = Pad3Width; // every keystream register fits in this

   // top term of each polynomial is implied
   localparam logic [Pad0Width-1:0] PolyPad0 =
      160'h00000800_00800004_00008000_00000100_00100001;
   localparam logic [Pad1Width-1:0] PolyPad1 =
      161'h0_00001000_02000010_00010000_10000100_00100001;
   localparam logic [Pad2Width-1:0] PolyPad2 =
      162'h0_00002000_02000010_00010000_10000100_00100001;
   localparam logic [Pad3Width-1:0] PolyPad3 =
      163'h0_00004000_04000040_00040000_20000200_00100001;
   localparam logic [PadSelWidth-1:0]   PolyPadSel   = 40'h04_0808_1041;
   localparam logic [InjectorWidth-1:0] PolyInjector = 32'h0821_0421;
   localparam logic [WordWidth-1:0]     PolyCrc      = 32'hB760_2B21;

   // configuration byte address of byte 0 of each register
   localparam int Pad0Base     = 0;
   localparam int Pad1Base     = 21;
   localparam int Pad2Base     = 42;
   localparam int Pad3Base     = 63;
   localparam int InjectorBase = 84;
   localparam int PadSelBase   = 88;

   // keystream register file, pads first so a tap's pad number is its index
   localparam int NumKsRegs   = 6;
   localparam int InjectorIdx = 4;
   localparam int PadSelIdx   = 5;
   localparam int RegWidth [NumKsRegs] = '{Pad0Width, Pad1Width, Pad2Width, Pad3Width,
                                           InjectorWidth, PadSelWidth};
   localparam int RegBase [NumKsRegs] = '{Pad0Base, Pad1Base, Pad2Base, Pad3Base,
                                          InjectorBase, PadSelBase};
   localparam logic [MaxPadWidth-1:0] RegPoly [NumKsRegs] = '{
      MaxPadWidth'(PolyPad0), MaxPadWidth'(PolyPad1), MaxPadWidth'(PolyPad2),
      MaxPadWidth'(PolyPad3), MaxPadWidth'(PolyInjector), MaxPadWidth'(PolyPadSel)};

   typedef enum logic [2:0] {Idle, Gather, StepFw, StepBw, Emit, Restore} ctrlState_t;
   typedef enum logic {Forward, Backward} stepDir_t;

   typedef struct packed {
      logic [1:0] pad;
      logic [7:0] index;
   } prnTap_t;

   // pad number and bit for each select value
   localparam prnTap_t PrnTable [32] = '{
      {2'd1, 8'd15},  {2'd0, 8'd37},  {2'd2, 8'd73},  {2'd3, 8'd99},
      {2'd0, 8'd121}, {2'd1, 8'd130}, {2'd3, 8'd15},  {2'd2, 8'd9},
      {2'd3, 8'd97},  {2'd2, 8'd140}, {2'd1, 8'd4},   {2'd0, 8'd88},
      {2'd0, 8'd33},  {2'd1, 8'd75},  {2'd2, 8'd35},  {2'd3, 8'd155},
      {2'd2, 8'd28},  {2'd1, 8'd150}, {2'd3, 8'd29},  {2'd0, 8'd144},
      {2'd0, 8'd127}, {2'd1, 8'd125}, {2'd2, 8'd0},   {2'd3, 8'd5},
      {2'd0, 8'd110}, {2'd3, 8'd87},  {2'd1, 8'd19},  {2'd2, 8'd82},
      {2'd0, 8'd48},  {2'd1, 8'd47},  {2'd2, 8'd46},  {2'd3, 8'd51}};

   function automatic prnTap_t prnTap(input logic [4:0] sel);
      return PrnTable[sel];
   endfunction

   function automatic logic [4:0] prnSelect(input logic [MaxPadWidth-1:0] padSel);
      return {padSel[31], padSel[3], padSel[5], padSel[19], padSel[8]};
   endfunction

   // step count n, always 32 to 63
   function automatic logic [PadAmountWidth-1:0] padAmountOf(
      input logic [MaxPadWidth-1:0] injector);
      return {1'b1, injector[30], injector[5], injector[9], injector[2], injector[27]};
   endfunction

   // one LFSR step of a w-bit register held in the low bits
   function automatic logic [MaxPadWidth-1:0] lfsrStep(input logic [MaxPadWidth-1:0] r,
      input logic [MaxPadWidth-1:0] poly, input int w, input stepDir_t dir);
      logic [MaxPadWidth-1:0] mask;
      logic [MaxPadWidth-1:0] res;
      logic fb;
      mask = {MaxPadWidth{1'b1}} >> (MaxPadWidth - w);
      if (dir == Forward) begin
         fb  = r[w-1];
         res = ((r << 1) ^ ({MaxPadWidth{fb}} & poly)) & mask;
      end else begin
         fb       = r[0];  // inverse step, old top bit comes back
         res      = (r >> 1) ^ ({MaxPadWidth{fb}} & (poly >> 1));
         res[w-1] = fb;
      end
      return res;
   endfunction

   // config byte write, partial top bytes keep only the low bits of data
   function automatic logic [MaxPadWidth-1:0] cfgWrite(input logic [MaxPadWidth-1:0] r,
      input int w, input int base, input logic [CaddrWidth-1:0] caddr,
      input logic [ByteWidth-1:0] cdata);
      logic [MaxPadWidth-1:0] res;
      res = r;
      for (int i = 0; i < MaxPadWidth; i++) begin
         if (i < w && int'(caddr) == base + i / ByteWidth)
            res[i] = cdata[i % ByteWidth];
      end
      return res;
   endfunction

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the unconfuser testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module unConfuserTb \
   -f sim.f --Mdir obj_dir -o unConfuserSim

./obj_dir/unConfuserSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
   echo "run passed"
else
   echo "run failed"
   exit 1
fi

/* sim.f */
+incdir+include
hdl/unconfuserPkg.sv
hdl/keystreamIf.sv
hdl/byteFifo.sv
hdl/keystreamGen.sv
hdl/unconfuserCtrl.sv
hdl/unConfuser.sv
sim/unConfuserTb.sv

/* include/unconfuserModel.svh */
// unconfuser reference model
// mirrors keystream stepping and the backward CRC, one word at a time
`ifndef UNCONFUSER_MODEL_SVH
`define UNCONFUSER_MODEL_SVH

import unconfuserPkg::*;

// same layout as the generator, pads then injector then pad select
logic [MaxPadWidth-1:0] mdlReg [NumKsRegs];

function automatic void mdlClear();
   for (int r = 0; r < NumKsRegs; r++)
      mdlReg[r] = '0;
endfunction

// byte k of a register covers bits 8k to 8k+7, cut off at its width
function automatic void mdlConfig(input logic [CaddrWidth-1:0] addr,
   input logic [ByteWidth-1:0] data);
   int bitPos;
   for (int r = 0; r < NumKsRegs; r++) begin
      if (int'(addr) >= RegBase[r]) begin
         for (int b = 0; b < ByteWidth; b++) begin
            bitPos = (int'(addr) - RegBase[r]) * ByteWidth + b;
            if (bitPos < RegWidth[r])
               mdlReg[r][bitPos] = data[b];
         end
      end
   end
endfunction

// pad select bits 31, 3, 5, 19 and 8 pick the tap
function automatic logic mdlPrn();
   logic [4:0] sel;
   prnTap_t    tap;
   sel = {mdlReg[PadSelIdx][31], mdlReg[PadSelIdx][3], mdlReg[PadSelIdx][5],
          mdlReg[PadSelIdx][19], mdlReg[PadSelIdx][8]};
   tap = prnTap(sel);
   return mdlReg[tap.pad][tap.index];
endfunction

// n is 32 plus injector bits 30, 5, 9, 2 and 27 read as a binary number
function automatic int mdlStepCount();
   return 32 + 16 * int'(mdlReg[InjectorIdx][30]) + 8 * int'(mdlReg[InjectorIdx][5])
      + 4 * int'(mdlReg[InjectorIdx][9]) + 2 * int'(mdlReg[InjectorIdx][2])
      + int'(mdlReg[InjectorIdx][27]);
endfunction

// forward shifts left and feeds the old top bit back through the polynomial
function automatic void mdlShift(input int r, input stepDir_t dir);
   int                     w;
   logic                   top;
   logic [MaxPadWidth-1:0] poly;
   logic [MaxPadWidth-1:0] prev;
   w    = RegWidth[r];
   poly = RegPoly[r];
   prev = mdlReg[r];
   mdlReg[r] = '0;
   if (dir == Forward) begin
      top = prev[w-1];
      for (int i = 1; i < w; i++)
         mdlReg[r][i] = prev[i-1] ^ (top & poly[i]);
      mdlReg[r][0] = top & poly[0];
   end else begin
      top = prev[0]; // poly bit 0 is set so bit 0 holds the old top bit
      for (int i = 1; i < w; i++)
         mdlReg[r][i-1] = prev[i] ^ (top & poly[i]);
      mdlReg[r][w-1] = top;
   end
endfunction

function automatic void mdlStep(input stepDir_t dir);
   for (int r = 0; r < NumKsRegs; r++) begin
      if (r != InjectorIdx || dir == Forward)
         mdlShift(r, dir);
   end
endfunction

// one backward CRC step on the word
function automatic logic [WordWidth-1:0] mdlCrcBack(input logic [WordWidth-1:0] w,
   input logic prn);
   logic                 fb;
   logic [WordWidth-1:0] res;
   fb  = w[0] ^ prn;
   res = w >> 1;
   res[WordWidth-1] = fb;
   if (fb)
      res[WordWidth-2:0] = res[WordWidth-2:0] ^ PolyCrc[WordWidth-1:1];
   return res;
endfunction

// n forward, n backward with CRC, n forward again
function automatic logic [WordWidth-1:0] mdlUnconfuse(input logic [WordWidth-1:0] w);
   int                   n;
   logic [WordWidth-1:0] res;
   n   = mdlStepCount();
   res = w;
   repeat (n)
      mdlStep(Forward);
   for (int i = 0; i < n; i++) begin
      res = mdlCrcBack(res, mdlPrn()); // prn taken before the pads move
      mdlStep(Backward);
   end
   repeat (n)
      mdlStep(Forward);
   return res;
endfunction

`endif

/* sim/unConfuserTb.sv */
// unconfuser testbench
// directed tests against a reference model of keystream and backward CRC
`default_nettype none

module unConfuserTb;
   timeunit 1ns;
   timeprecision 100ps;

   `include "unconfuserModel.svh"

   logic                  Clk;
   logic                  Reset;
   logic                  PushIn;
   logic [ByteWidth-1:0]  Din;
   logic [CaddrWidth-1:0] Caddr;
   logic [ByteWidth-1:0]  Cdata;
   logic                  Cpush;
   logic                  StopIn;
   logic                  PushOut;
   logic [ByteWidth-1:0]  Dout;

   logic [ByteWidth-1:0] expQ [$]; // predicted output bytes in order
   int                   seed;

   unConfuser #(.FifoDepth(FifoDepth)) unConfuser_inst (
      .Clk(Clk), .Reset(Reset),
      .PushIn(PushIn), .Din(Din),
      .Caddr(Caddr), .Cdata(Cdata), .Cpush(Cpush),
      .StopIn(StopIn),
      .PushOut(PushOut), .Dout(Dout)
   );

   initial begin
      Clk = 1'b0;
      forever #5 Clk = ~Clk;
   end

   task automatic checkByte(input string name, input logic [ByteWidth-1:0] got,
      input logic [ByteWidth-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "byte mismatch");
      end
   endtask

   task automatic checkLevel(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "level mismatch");
      end
   endtask

   task automatic reportTimeout(input string what);
      $display("Timed out at %0t while waiting for %s", $time, what);
      $display("Simulation failed");
      $fatal(1, "timeout");
   endtask

   task automatic applyReset();
      Reset = 1'b1;
      repeat (3) @(posedge Clk);
      #1 Reset = 1'b0;
   endtask

   // one configuration byte, mirrored into the model
   task automatic writeConfig(input logic [CaddrWidth-1:0] addr,
      input logic [ByteWidth-1:0] data);
      @(posedge Clk);
      #1;
      Cpush = 1'b1;
      Caddr = addr;
      Cdata = data;
      mdlConfig(addr, data);
      @(posedge Clk);
      #1 Cpush = 1'b0;
   endtask

   // random words back to back, first byte becomes the MSB
   task automatic pushWords(input int count);
      logic [WordWidth-1:0] w;
      logic [WordWidth-1:0] res;
      for (int k = 0; k < count; k++) begin
         w   = $random(seed);
         res = mdlUnconfuse(w);
         for (int i = 0; i < 4; i++)
            expQ.push_back(res[WordWidth-1-ByteWidth*i -: ByteWidth]);
         for (int i = 0; i < 4; i++) begin
            @(posedge Clk);
            #1;
            PushIn = 1'b1;
            Din    = w[WordWidth-1-ByteWidth*i -: ByteWidth];
         end
      end
      @(posedge Clk);
      #1 PushIn = 1'b0;
   endtask

   // take count bytes off the output, optionally with random StopIn
   task automatic drainBytes(input int count, input bit randomStop);
      int                   got;
      int                   idleCycles;
      bit                   holding;
      logic [ByteWidth-1:0] held;
      got        = 0;
      idleCycles = 0;
      holding    = 1'b0;
      held       = '0;
      while (got < count) begin
         @(posedge Clk);
         #1 StopIn = randomStop ? 1'($random(seed)) : 1'b0;
         @(negedge Clk); // outputs settled mid cycle
         if (holding) begin
            checkLevel("PushOut", PushOut, 1'b1);
            checkByte("Dout", Dout, held);
         end
         holding = PushOut && StopIn;
         held    = Dout;
         if (PushOut && !StopIn) begin
            checkByte("Dout", Dout, expQ.pop_front());
            got++;
            idleCycles = 0;
         end else begin
            idleCycles++;
         end
         if (idleCycles > 400)
            reportTimeout("an output byte");
      end
   endtask

   // pads may only be reconfigured with the control unit idle
   task automatic waitIdle();
      int cycles;
      cycles = 0;
      while (unConfuser_inst.unconfuserCtrl_inst.state != Idle) begin
         @(negedge Clk);
         cycles++;
         if (cycles > 300)
            reportTimeout("the control unit to go idle");
      end
      @(negedge Clk);
   endtask

   task automatic idleAfterReset();
      repeat (20) begin
         @(negedge Clk);
         checkLevel("PushOut", PushOut, 1'b0);
      end
   endtask

   task automatic zeroConfigWord();
      pushWords(1); // zero pads, so prn 0 and n 32
      drainBytes(4, 1'b0);
      waitIdle();
   endtask

   task automatic fullConfigStream();
      for (int a = 0; a < PadSelBase + PadSelWidth / ByteWidth; a++)
         writeConfig(CaddrWidth'(a), ByteWidth'($random(seed)));
      pushWords(4);
      drainBytes(16, 1'b0);
      pushWords(3);    // keystream carries on from the previous burst
      drainBytes(12, 1'b0);
      waitIdle();
   endtask

   task automatic randomStopIn();
      pushWords(4);
      drainBytes(16, 1'b1);
      waitIdle();
   endtask

   task automatic injectorReload();
      int                   nBefore;
      int                   nAfter;
      logic [ByteWidth-1:0] lowByte;
      checkLevel("PushOut", PushOut, 1'b0);
      nBefore = mdlStepCount();
      lowByte = ByteWidth'($random(seed));
      writeConfig(CaddrWidth'(InjectorBase), lowByte);
      for (int a = InjectorBase + 1; a < PadSelBase; a++)
         writeConfig(CaddrWidth'(a), ByteWidth'($random(seed)));
      nAfter = mdlStepCount();
      if (nAfter == nBefore)
         writeConfig(CaddrWidth'(InjectorBase), lowByte ^ 8'h04); // flips injector bit 2
      pushWords(2);
      drainBytes(8, 1'b1);
      waitIdle();
      checkLevel("PushOut", PushOut, 1'b0);
   endtask

   initial begin
      seed   = 32'h8ef4_c664;
      Reset  = 1'b1;
      PushIn = 1'b0;
      Din    = '0;
      Caddr  = '0;
      Cdata  = '0;
      Cpush  = 1'b0;
      StopIn = 1'b0;
      mdlClear();
      applyReset();
      idleAfterReset();
      zeroConfigWord();
      fullConfigStream();
      randomStopIn();
      injectorReload();
      if (expQ.size() != 0) begin
         $display("%0d predicted bytes never came out", expQ.size());
         $display("Simulation failed");
         $fatal(1, "bytes missing");
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire
